// ==== cache_pkg.sv ====
// shared definitions of the hit-count cache
// word address and data word types
// controller and line sequencer state encodings
// default sizes for the top level parameters

package cache_pkg;

	// addresses count words, not bytes
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	typedef enum logic [2:0] {
		st_idle,
		st_check,
		st_wait_busy,
		st_wait_done,
		st_ack
	} ctrl_state_t;

	// write-back of the old region, then fill of the new one
	typedef enum logic [1:0] {
		ln_idle,
		ln_flush,
		ln_fill
	} line_state_t;

	localparam int default_num_lines  = 4;
	localparam int default_line_words = 4;
	localparam int default_hit_bits   = 8;

endpackage

// ==== cache_line.sv ====
// one line of the fully associative cache
// region tag, valid and dirty flags, word storage
// saturating hit counter for the replacement policy
// flush/fill sequencer on a private memory request port

`timescale 1ns/1ps

module cache_line import cache_pkg::*; #(
	parameter int LINE_WORDS = default_line_words,
	parameter int HIT_BITS   = default_hit_bits
) (
	input  logic                clk,
	input  logic                reset_n,
	input  addr_t               look_addr,
	input  logic                access,
	input  logic                wr,
	input  data_t               wdata,
	input  logic                evict,
	output logic                hit,
	output data_t               rdata,
	output logic [HIT_BITS-1:0] hit_count,
	output logic                ready,
	output logic                mem_req,
	output logic                mem_we,
	output addr_t               mem_addr,
	output data_t               mem_wdata,
	input  logic                mem_ack,
	input  data_t               mem_rdata
);

	localparam int IDX_BITS = $clog2(LINE_WORDS);
	localparam int TAG_BITS = $bits(addr_t) - IDX_BITS;
	localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(LINE_WORDS - 1);

	line_state_t         state;
	logic [TAG_BITS-1:0] tag;
	logic [TAG_BITS-1:0] old_tag;
	logic                valid;
	logic                dirty;
	logic [IDX_BITS-1:0] idx;
	data_t               words [LINE_WORDS];

	logic [TAG_BITS-1:0] look_tag;
	logic [IDX_BITS-1:0] look_idx;
	logic                fill_ack;
	logic                fill_last;

	assign look_tag = look_addr[$bits(addr_t)-1:IDX_BITS];
	assign look_idx = look_addr[IDX_BITS-1:0];

	assign hit   = valid && (look_tag == tag);
	assign rdata = words[look_idx];
	assign ready = (state == ln_idle);

	// flush addresses the old region, fill the new one
	assign mem_req   = (state != ln_idle);
	assign mem_we    = (state == ln_flush);
	assign mem_addr  = {(state == ln_flush) ? old_tag : tag, idx};
	assign mem_wdata = words[idx];

	assign fill_ack  = (state == ln_fill) && mem_ack;
	assign fill_last = fill_ack && (idx == LAST_IDX);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state   <= ln_idle;
			tag     <= '0;
			old_tag <= '0;
			valid   <= 1'b0;
			dirty   <= 1'b0;
			idx     <= '0;
		end else begin
			case (state)
				ln_idle: begin
					if (evict) begin
						old_tag <= tag;
						tag     <= look_tag;
						valid   <= 1'b0;
						idx     <= '0;
						// a clean line skips the write-back
						state   <= dirty ? ln_flush : ln_fill;
					end else if (wr && hit) begin
						dirty <= 1'b1;
					end
				end
				ln_flush: begin
					if (mem_ack) begin
						// index wraps back to zero for the fill
						idx <= idx + 1'b1;
						if (idx == LAST_IDX) begin
							dirty <= 1'b0;
							state <= ln_fill;
						end
					end
				end
				ln_fill: begin
					if (mem_ack) begin
						idx <= idx + 1'b1;
						if (idx == LAST_IDX) begin
							valid <= 1'b1;
							state <= ln_idle;
						end
					end
				end
				default: begin
					state <= ln_idle;
				end
			endcase
		end
	end

	// count saturates, a fresh region starts from zero
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			hit_count <= '0;
		end else if (fill_last) begin
			hit_count <= '0;
		end else if (access && hit && (hit_count != '1)) begin
			hit_count <= hit_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_ack) begin
			words[idx] <= mem_rdata;
		end else if (wr && hit) begin
			words[look_idx] <= wdata;
		end
	end

	// the controller only evicts a line that has finished its last refill
	assert property (@(posedge clk) disable iff (!reset_n) evict |-> ready)
		else $error("cache_line: evict while line is busy");

endmodule

// ==== victim_select.sv ====
// eviction victim selection
// marks the line with the lowest hit count, one-hot

`timescale 1ns/1ps

module victim_select import cache_pkg::*; #(
	parameter int NUM_LINES = default_num_lines,
	parameter int HIT_BITS  = default_hit_bits
) (
	input  logic [NUM_LINES-1:0][HIT_BITS-1:0] hit_counts,
	output logic [NUM_LINES-1:0]               victim
);

	logic [HIT_BITS-1:0] min_count;

	always_comb begin
		min_count = hit_counts[0];
		victim    = '0;
		victim[0] = 1'b1;
		for (int i = 1; i < NUM_LINES; i++) begin
			// strict compare, so a tie stays with the lower index
			if (hit_counts[i] < min_count) begin
				min_count = hit_counts[i];
				victim    = '0;
				victim[i] = 1'b1;
			end
		end
	end

endmodule

// ==== mem_arbiter.sv ====
// shared memory port arbiter
// fixed priority, lowest requesting line wins
// routes the memory acknowledge back to the granted line only

`timescale 1ns/1ps

module mem_arbiter import cache_pkg::*; #(
	parameter int NUM_LINES = default_num_lines
) (
	input  logic [NUM_LINES-1:0]  line_req,
	input  logic [NUM_LINES-1:0]  line_we,
	input  addr_t [NUM_LINES-1:0] line_addr,
	input  data_t [NUM_LINES-1:0] line_wdata,
	input  logic                  mem_ack,
	output logic [NUM_LINES-1:0]  line_ack,
	output logic                  mem_req,
	output logic                  mem_we,
	output addr_t                 mem_addr,
	output data_t                 mem_wdata
);

	logic [NUM_LINES-1:0] grant;

	// isolate the lowest set request bit
	assign grant    = line_req & (~line_req + 1'b1);
	assign mem_req  = |line_req;
	assign line_ack = mem_ack ? grant : '0;

	always_comb begin
		mem_we    = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (grant[i]) begin
				mem_we    = line_we[i];
				mem_addr  = line_addr[i];
				mem_wdata = line_wdata[i];
			end
		end
	end

	// evictions are serialized, so only one line is ever flushing or filling
	always_comb begin
		assert final ($onehot0(line_req))
			else $error("mem_arbiter: more than one line requesting");
	end

endmodule

// ==== cache_ctrl.sv ====
// cache controller
// lookup, evict and retry FSM, one host request at a time
// read word selection from the one-hot hit vector
// single cycle host acknowledge

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
	parameter int NUM_LINES = default_num_lines,
	parameter int HIT_BITS  = default_hit_bits
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  cpu_req,
	input  logic                  cpu_we,
	input  addr_t                 cpu_addr,
	input  data_t                 cpu_wdata,
	input  logic [NUM_LINES-1:0]  line_hit,
	input  data_t [NUM_LINES-1:0] line_rdata,
	input  logic [NUM_LINES-1:0]  line_ready,
	input  logic [NUM_LINES-1:0]  victim,
	output logic                  cpu_ack,
	output data_t                 cpu_rdata,
	output addr_t                 look_addr,
	output logic                  access,
	output logic                  wr,
	output data_t                 wdata,
	output logic [NUM_LINES-1:0]  evict
);

	ctrl_state_t          state;
	logic [NUM_LINES-1:0] victim_q;
	logic [HIT_BITS-1:0]  evict_cnt;
	logic                 req_we;
	addr_t                req_addr;
	data_t                req_wdata;
	logic                 any_hit;
	data_t                sel_rdata;

	assign any_hit   = |line_hit;
	assign look_addr = req_addr;
	assign wdata     = req_wdata;
	assign access    = (state == st_check);
	assign wr        = access && req_we && any_hit;
	assign evict     = (access && !any_hit) ? victim : '0;
	assign cpu_ack   = (state == st_ack);

	always_comb begin
		sel_rdata = '0;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (line_hit[i]) begin
				sel_rdata = sel_rdata | line_rdata[i];
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state     <= st_idle;
			victim_q  <= '0;
			evict_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (cpu_req) begin
						evict_cnt <= '0;
						state     <= st_check;
					end
				end
				st_check: begin
					if (any_hit) begin
						state <= st_ack;
					end else begin
						victim_q <= victim;
						if (evict_cnt != '1) begin
							evict_cnt <= evict_cnt + 1'b1;
						end
						state <= st_wait_busy;
					end
				end
				// victim drops ready once its sequencer has started
				st_wait_busy: begin
					if ((line_ready & victim_q) == '0) begin
						state <= st_wait_done;
					end
				end
				st_wait_done: begin
					if ((line_ready & victim_q) != '0) begin
						state <= st_check;
					end
				end
				st_ack: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == st_idle) && cpu_req) begin
			req_we    <= cpu_we;
			req_addr  <= cpu_addr;
			req_wdata <= cpu_wdata;
		end
		if (access && any_hit) begin
			cpu_rdata <= sel_rdata;
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n) $onehot0(evict))
		else $error("cache_ctrl: evict vector not one-hot");

	// two lines holding the same region
	assert property (@(posedge clk) disable iff (!reset_n) $onehot0(line_hit))
		else $error("cache_ctrl: multiple lines hit");

	// refilled victim must serve the retried access
	assert property (@(posedge clk) disable iff (!reset_n)
		(access && (evict_cnt != '0)) |-> any_hit)
		else $error("cache_ctrl: retry after eviction missed");

endmodule

// ==== hybrid_cache.sv ====
// top level of the hit-count cache
// NUM_LINES cache lines, victim selector, memory arbiter, controller

`timescale 1ns/1ps

module hybrid_cache import cache_pkg::*; #(
	parameter int NUM_LINES  = default_num_lines,
	parameter int LINE_WORDS = default_line_words,
	parameter int HIT_BITS   = default_hit_bits
) (
	input  logic  clk,
	input  logic  reset_n,
	input  logic  cpu_req,
	input  logic  cpu_we,
	input  addr_t cpu_addr,
	input  data_t cpu_wdata,
	output logic  cpu_ack,
	output data_t cpu_rdata,
	output logic  mem_req,
	output logic  mem_we,
	output addr_t mem_addr,
	output data_t mem_wdata,
	input  logic  mem_ack,
	input  data_t mem_rdata
);

	addr_t                              look_addr;
	logic                               access;
	logic                               wr;
	data_t                              wdata;
	logic [NUM_LINES-1:0]               evict;
	logic [NUM_LINES-1:0]               victim;
	logic [NUM_LINES-1:0]               line_hit;
	data_t [NUM_LINES-1:0]              line_rdata;
	logic [NUM_LINES-1:0][HIT_BITS-1:0] hit_counts;
	logic [NUM_LINES-1:0]               line_ready;
	logic [NUM_LINES-1:0]               line_req;
	logic [NUM_LINES-1:0]               line_we;
	addr_t [NUM_LINES-1:0]              line_addr;
	data_t [NUM_LINES-1:0]              line_wdata;
	logic [NUM_LINES-1:0]               line_ack;

	for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
		cache_line #(
			.LINE_WORDS (LINE_WORDS),
			.HIT_BITS   (HIT_BITS)
		) line0 (
			.clk       (clk),
			.reset_n   (reset_n),
			.look_addr (look_addr),
			.access    (access),
			.wr        (wr),
			.wdata     (wdata),
			.evict     (evict[i]),
			.hit       (line_hit[i]),
			.rdata     (line_rdata[i]),
			.hit_count (hit_counts[i]),
			.ready     (line_ready[i]),
			.mem_req   (line_req[i]),
			.mem_we    (line_we[i]),
			.mem_addr  (line_addr[i]),
			.mem_wdata (line_wdata[i]),
			.mem_ack   (line_ack[i]),
			.mem_rdata (mem_rdata)
		);
	end

	victim_select #(
		.NUM_LINES (NUM_LINES),
		.HIT_BITS  (HIT_BITS)
	) victim0 (
		.hit_counts (hit_counts),
		.victim     (victim)
	);

	mem_arbiter #(
		.NUM_LINES (NUM_LINES)
	) arbiter0 (
		.line_req   (line_req),
		.line_we    (line_we),
		.line_addr  (line_addr),
		.line_wdata (line_wdata),
		.mem_ack    (mem_ack),
		.line_ack   (line_ack),
		.mem_req    (mem_req),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	cache_ctrl #(
		.NUM_LINES (NUM_LINES),
		.HIT_BITS  (HIT_BITS)
	) ctrl0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.cpu_req    (cpu_req),
		.cpu_we     (cpu_we),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.line_hit   (line_hit),
		.line_rdata (line_rdata),
		.line_ready (line_ready),
		.victim     (victim),
		.cpu_ack    (cpu_ack),
		.cpu_rdata  (cpu_rdata),
		.look_addr  (look_addr),
		.access     (access),
		.wr         (wr),
		.wdata      (wdata),
		.evict      (evict)
	);

endmodule

// ==== tb_clock.sv ====
// testbench clock and reset generator
// free running clock, reset held low for a few cycles

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_n = 1'b1;
	end

endmodule

// ==== tb_hybrid_cache.sv ====
// testbench for the hit-count cache
// random host reads and writes over twice as many regions as lines
// memory responder with random ack delay and a transfer log
// reference model of tags, flags, data and hit counts

`timescale 1ns/1ps

module tb_hybrid_cache import cache_pkg::*; ();

	localparam int NUM_LINES     = 4;
	localparam int LINE_WORDS    = 4;
	localparam int HIT_BITS      = 8;
	localparam int IDX_BITS      = $clog2(LINE_WORDS);
	localparam int NUM_REQS      = 400;
	localparam int NUM_REGIONS   = 2 * NUM_LINES;
	localparam int MEM_WORDS     = 256;
	localparam int CLK_PERIOD    = 8;
	localparam int DRIVE_DELAY   = 1;
	localparam int WORST_MISS    = 40;
	localparam int WATCHDOG_NS   = (NUM_REQS * WORST_MISS + 1000) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'h869f5028;

	logic  clk;
	logic  reset_n;
	logic  cpu_req;
	logic  cpu_we;
	addr_t cpu_addr;
	data_t cpu_wdata;
	logic  cpu_ack;
	data_t cpu_rdata;
	logic  mem_req;
	logic  mem_we;
	addr_t mem_addr;
	data_t mem_wdata;
	logic  mem_ack;
	data_t mem_rdata;

	// model of the lines
	int    line_region [NUM_LINES];
	logic  line_valid  [NUM_LINES];
	logic  line_dirty  [NUM_LINES];
	int    line_hits   [NUM_LINES];
	data_t line_data   [NUM_LINES][LINE_WORDS];

	// last written values, model memory, responder memory
	data_t host_view [MEM_WORDS];
	data_t backing   [MEM_WORDS];
	data_t mem_words [MEM_WORDS];

	logic  log_we   [$];
	addr_t log_addr [$];
	data_t log_data [$];

	tb_clock #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (4)
	) clock0 (
		.clk     (clk),
		.reset_n (reset_n)
	);

	hybrid_cache #(
		.NUM_LINES  (NUM_LINES),
		.LINE_WORDS (LINE_WORDS),
		.HIT_BITS   (HIT_BITS)
	) dut0 (
		.clk       (clk),
		.reset_n   (reset_n),
		.cpu_req   (cpu_req),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic verify_word(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic match_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// mixes every address bit into the initial word
	function automatic data_t fill_pattern(input addr_t a);
		return (a * 32'h9e3779b1) ^ 32'h1234abcd;
	endfunction

	task automatic take_mem_access(input logic we, input addr_t addr, input data_t wdata);
		logic  got_we;
		addr_t got_addr;
		data_t got_data;
		if (log_we.size() == 0) begin
			stop_on_error("an expected memory access never happened");
		end
		got_we   = log_we.pop_front();
		got_addr = log_addr.pop_front();
		got_data = log_data.pop_front();
		expect_bit("mem_we", got_we, we);
		match_addr("mem_addr", got_addr, addr);
		if (we) begin
			verify_word("mem_wdata", got_data, wdata);
		end
	endtask

	task automatic host_access(input logic we, input addr_t addr, input data_t wdata);
		int region;
		int word;
		int line;
		int cycles;
		int base;
		region = int'(addr >> IDX_BITS);
		word   = int'(addr % LINE_WORDS);
		line   = -1;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (line_valid[i] && (line_region[i] == region)) begin
				line = i;
			end
		end
		cpu_req   = 1'b1;
		cpu_we    = we;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		@(posedge clk);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!cpu_ack);
		if (line >= 0) begin
			if (cycles != 2) begin
				stop_on_error($sformatf("hit at %0t took %0d cycles instead of 2", $time, cycles));
			end
		end else begin
			// least hits wins, ties to the lowest index
			line = 0;
			for (int i = 1; i < NUM_LINES; i++) begin
				if (line_hits[i] < line_hits[line]) begin
					line = i;
				end
			end
			if (line_dirty[line]) begin
				base = line_region[line] * LINE_WORDS;
				for (int w = 0; w < LINE_WORDS; w++) begin
					take_mem_access(1'b1, addr_t'(base + w), line_data[line][w]);
					backing[base + w] = line_data[line][w];
				end
			end
			base = region * LINE_WORDS;
			for (int w = 0; w < LINE_WORDS; w++) begin
				take_mem_access(1'b0, addr_t'(base + w), '0);
				line_data[line][w] = backing[base + w];
			end
			line_region[line] = region;
			line_valid[line]  = 1'b1;
			line_dirty[line]  = 1'b0;
			line_hits[line]   = 0;
		end
		if (log_we.size() != 0) begin
			stop_on_error($sformatf("unexpected memory access during request at %0t", $time));
		end
		if (line_hits[line] < (1 << HIT_BITS) - 1) begin
			line_hits[line]++;
		end
		if (we) begin
			line_data[line][word] = wdata;
			line_dirty[line]      = 1'b1;
			host_view[int'(addr)] = wdata;
		end else begin
			verify_word("cpu_rdata", cpu_rdata, host_view[int'(addr)]);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		cpu_req = 1'b0;
	endtask

	task automatic compare_memory();
		data_t seen;
		if (log_we.size() != 0) begin
			stop_on_error("memory accesses left over after the last request");
		end
		for (int a = 0; a < MEM_WORDS; a++) begin
			verify_word($sformatf("mem_words[%0d]", a), mem_words[a], backing[a]);
			// dirty data still sitting in a line
			seen = mem_words[a];
			for (int i = 0; i < NUM_LINES; i++) begin
				if (line_valid[i] && line_dirty[i] && (line_region[i] == (a >> IDX_BITS))) begin
					seen = line_data[i][a % LINE_WORDS];
				end
			end
			verify_word($sformatf("word %0d with dirty lines", a), seen, host_view[a]);
		end
	endtask

	// acks each access after 0 to 3 idle cycles
	always begin
		@(posedge clk);
		#DRIVE_DELAY;
		while (reset_n && mem_req) begin
			repeat ($urandom % 4) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
			if (mem_addr >= MEM_WORDS) begin
				stop_on_error($sformatf("memory access to %h is outside the test range", mem_addr));
			end
			if (mem_we) begin
				mem_words[int'(mem_addr)] = mem_wdata;
			end else begin
				mem_rdata = mem_words[int'(mem_addr)];
			end
			log_we.push_back(mem_we);
			log_addr.push_back(mem_addr);
			log_data.push_back(mem_we ? mem_wdata : mem_rdata);
			mem_ack = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
			mem_ack = 1'b0;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("watchdog timeout, the requests did not complete in time");
	end

	initial begin
		int    region;
		addr_t addr;
		logic  we;
		data_t wdata;
		void'($urandom(SEED));
		cpu_req   = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_words[a] = fill_pattern(addr_t'(a));
			backing[a]   = mem_words[a];
			host_view[a] = mem_words[a];
		end
		for (int i = 0; i < NUM_LINES; i++) begin
			line_region[i] = 0;
			line_valid[i]  = 1'b0;
			line_dirty[i]  = 1'b0;
			line_hits[i]   = 0;
		end
		wait (reset_n === 1'b1);
		repeat (4) begin
			@(negedge clk);
			expect_bit("cpu_ack", cpu_ack, 1'b0);
			expect_bit("mem_req", mem_req, 1'b0);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		for (int n = 0; n < NUM_REQS; n++) begin
			// regions spread out so the tags differ in several bits
			region = int'($urandom % NUM_REGIONS) * 7 + 3;
			addr   = addr_t'(region * LINE_WORDS) + ($urandom % LINE_WORDS);
			we     = ($urandom % 2) == 1;
			wdata  = $urandom;
			host_access(we, addr, wdata);
			if (($urandom % 4) == 0) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
		end
		repeat (4) @(posedge clk);
		compare_memory();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== flist.f ====
cache_pkg.sv
cache_line.sv
victim_select.sv
mem_arbiter.sv
cache_ctrl.sv
hybrid_cache.sv
tb_clock.sv
tb_hybrid_cache.sv
